//--- source/chip8_pkg.sv
// Chip-8 machine constants and the memory port request shared by all requesters
// Memory is byte wide with a 12-bit address space, so PC wraps at 4 KiB

`default_nettype none

package chip8_pkg;

    localparam int MEM_ADDR_W  = 12;
    localparam int BYTE_W      = 8;
    localparam int INSTR_W     = 16;
    localparam int INSTR_BYTES = 2;
    localparam int NUM_VREGS   = 16;

    localparam logic [MEM_ADDR_W-1:0] PC_START = 12'h200;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // One access on the single memory port
    typedef struct packed {
        mem_addr_t         addr;
        logic              we;
        logic [BYTE_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- source/host_map_pkg.sv
// Host register map, run state encoding and the host bus bundle
// Offsets outside the map read back as UNMAPPED_VALUE

`default_nettype none

package host_map_pkg;

    // V0-VF occupy offsets 0x0 to 0xF
    localparam logic [17:0] REG_V_BASE      = 18'h00;
    localparam logic [17:0] REG_I           = 18'h10;
    localparam logic [17:0] REG_SOUND_TIMER = 18'h11;
    localparam logic [17:0] REG_DELAY_TIMER = 18'h12;
    localparam logic [17:0] REG_PC          = 18'h14;
    localparam logic [17:0] REG_STATE       = 18'h16;
    localparam logic [17:0] REG_MEM         = 18'h19;

    localparam logic [31:0] UNMAPPED_VALUE = 32'd101;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        STEP    = 2'd1,
        PAUSED  = 2'd2
    } run_state_t;

    typedef struct packed {
        logic        chipselect;
        logic        write;
        logic [17:0] address;
        logic [31:0] writedata;
    } host_bus_t;

endpackage

`default_nettype wire

//--- source/program_memory.sv
// Single-port 4096x8 RAM with registered read, contents are not reset
// A write returns the written byte on rdata in the next cycle

`timescale 1ns/1ps
`default_nettype none

module program_memory
    import chip8_pkg::*;
(
    input  logic              clk,
    input  mem_req_t          mem_req,
    output logic [BYTE_W-1:0] rdata
);

    logic [BYTE_W-1:0] mem [2**MEM_ADDR_W];

    // Write-first behaviour on the shared port
    always_ff @(posedge clk) begin
        if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
            rdata <= mem_req.wdata;
        end else begin
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

//--- source/memory_arbiter.sv
// Fixed priority, host always wins the memory port and the fetcher waits
// Read data returns one cycle after the grant to whoever owned the port

`timescale 1ns/1ps
`default_nettype none

module memory_arbiter
    import chip8_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     host_request,
    input  mem_req_t host_req,
    input  logic     fetch_request,
    input  mem_req_t fetch_req,
    output logic     fetch_grant,
    output mem_req_t mem_req
);

    // Set when the fetcher owned the port in the previous cycle
    logic fetch_owner;

    assign fetch_grant = fetch_request && !host_request;

    always_comb begin
        if (host_request) begin
            mem_req = host_req;
        end else begin
            mem_req = fetch_req;
            // No write reaches memory unless someone is actually granted
            mem_req.we = fetch_request && fetch_req.we;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_owner <= 1'b0;
        end else begin
            fetch_owner <= fetch_grant;
        end
    end

    // Data returned to the fetcher always comes from a read cycle
    fetch_owner_reads: assert property (@(posedge clk) disable iff (reset)
        fetch_owner |-> !$past(mem_req.we));

endmodule

`default_nettype wire

//--- source/fetch_sequencer.sv
// Fetches the two instruction bytes at PC and paces one instruction per CYCLE_LENGTH
// An instruction in progress always completes, next PC is always PC plus 2

`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
    import chip8_pkg::*;
    import host_map_pkg::*;
#(
    parameter int CYCLE_LENGTH = 50000
) (
    input  logic               clk,
    input  logic               reset,
    input  run_state_t         state,
    input  logic               pc_load,
    input  mem_addr_t          pc_value,
    output logic               fetch_request,
    output mem_req_t           fetch_req,
    input  logic               fetch_grant,
    input  logic [BYTE_W-1:0]  mem_rdata,
    output mem_addr_t          pc,
    output logic [INSTR_W-1:0] instruction,
    output logic               step_done
);

    localparam int CNT_W = $clog2(CYCLE_LENGTH + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CYCLE_LENGTH - 1);

    typedef enum logic [2:0] {
        IDLE, REQ_HI, WAIT_HI, REQ_LO, WAIT_LO, DONE
    } fetch_phase_t;

    fetch_phase_t      phase;
    logic [CNT_W-1:0]  cycle_count;
    logic [BYTE_W-1:0] hi_byte;
    logic              boundary;

    // Instruction ends once fetched and the minimum cycle count is reached
    assign boundary = (phase == DONE) && (cycle_count == LAST_COUNT);
    assign step_done = boundary && (state == STEP);

    assign fetch_request = (phase == REQ_HI) || (phase == REQ_LO);
    assign fetch_req.addr = (phase == REQ_LO) ? pc + 1'b1 : pc;
    assign fetch_req.we = 1'b0;
    assign fetch_req.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= IDLE;
            cycle_count <= '0;
            pc <= PC_START;
            instruction <= '0;
        end else begin
            if (phase != IDLE && cycle_count != LAST_COUNT) begin
                cycle_count <= cycle_count + 1'b1;
            end
            case (phase)
                IDLE: begin
                    if (state != PAUSED) begin
                        phase <= REQ_HI;
                    end
                end
                REQ_HI: if (fetch_grant) phase <= WAIT_HI;
                WAIT_HI: begin
                    phase <= REQ_LO;
                end
                REQ_LO: if (fetch_grant) phase <= WAIT_LO;
                WAIT_LO: begin
                    instruction <= {hi_byte, mem_rdata};
                    phase <= DONE;
                end
                DONE: begin
                    if (boundary) begin
                        cycle_count <= '0;
                        phase <= (state == RUNNING) ? REQ_HI : IDLE;
                    end
                end
                default: phase <= IDLE;
            endcase
            // Host write of PC beats the advance
            if (pc_load) begin
                pc <= pc_value;
            end else if (boundary) begin
                pc <= pc + MEM_ADDR_W'(INSTR_BYTES);
            end
        end
    end

    // High byte of the instruction sits at PC
    always_ff @(posedge clk) begin
        if (phase == WAIT_HI) begin
            hi_byte <= mem_rdata;
        end
    end

    // A waiting fetch stays a stable read until the arbiter lets it through
    fetch_held_read: assert property (@(posedge clk) disable iff (reset)
        (fetch_request && !fetch_grant && !pc_load) |=>
            (fetch_request && !fetch_req.we && $stable(fetch_req.addr)));

endmodule

`default_nettype wire

//--- source/countdown_timers.sv
// Delay and sound timers decrement once per TICK_DIVISOR clocks, stopping at 0
// A host load wins over a tick in the same cycle

`timescale 1ns/1ps
`default_nettype none

module countdown_timers
    import chip8_pkg::*;
    import host_map_pkg::*;
#(
    parameter int TICK_DIVISOR = 833333
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [1:0]        timer_load,
    input  logic [BYTE_W-1:0] timer_value,
    input  run_state_t        state,
    output logic [BYTE_W-1:0] delay_count,
    output logic [BYTE_W-1:0] sound_count,
    output logic              sound_on
);

    localparam int TICK_W = $clog2(TICK_DIVISOR + 1);

    logic [TICK_W-1:0] tick_count;
    logic              tick;
    // Index 0 is delay, index 1 is sound
    logic [BYTE_W-1:0] counts [2];

    assign tick = (tick_count == TICK_W'(TICK_DIVISOR - 1));
    assign delay_count = counts[0];
    assign sound_count = counts[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_count <= '0;
        end else if (tick) begin
            tick_count <= '0;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counts[0] <= '0;
            counts[1] <= '0;
            sound_on <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (timer_load[i]) begin
                    counts[i] <= timer_value;
                end else if (tick && counts[i] != '0) begin
                    counts[i] <= counts[i] - 1'b1;
                end
            end
            // Tone only while the machine runs freely
            sound_on <= (counts[1] != '0) && (state == RUNNING);
        end
    end

endmodule

`default_nettype wire

//--- source/host_interface.sv
// Host register window, one access per cycle with chipselect high
// A memory byte is returned by the second of two REG_MEM accesses

`timescale 1ns/1ps
`default_nettype none

module host_interface
    import chip8_pkg::*;
    import host_map_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  host_bus_t          bus,
    output logic [31:0]        data_out,
    output mem_req_t           mem_req,
    output logic               mem_request,
    input  logic [BYTE_W-1:0]  mem_rdata,
    input  mem_addr_t          pc,
    input  logic [INSTR_W-1:0] instruction,
    output logic               pc_load,
    output mem_addr_t          pc_value,
    output run_state_t         state,
    input  logic               step_done,
    output logic [1:0]         timer_load,
    output logic [BYTE_W-1:0]  timer_value,
    input  logic [BYTE_W-1:0]  delay_count,
    input  logic [BYTE_W-1:0]  sound_count
);

    logic [BYTE_W-1:0] v_regs [NUM_VREGS];
    logic [15:0]       i_reg;
    mem_addr_t         mem_addr;
    logic [BYTE_W-1:0] mem_byte;
    logic              mem_pending;
    logic              host_write;
    logic              sel_v;
    logic [31:0]       read_value;

    assign host_write = bus.chipselect && bus.write;
    assign sel_v = (bus.address[17:4] == REG_V_BASE[17:4]);

    // Memory access goes straight to the arbiter in the access cycle
    assign mem_request = bus.chipselect && (bus.address == REG_MEM);
    assign mem_req.addr = bus.write ? bus.writedata[19:8] : mem_addr;
    assign mem_req.we = mem_request && bus.write && bus.writedata[20];
    assign mem_req.wdata = bus.writedata[7:0];

    assign pc_load = host_write && (bus.address == REG_PC);
    assign pc_value = bus.writedata[MEM_ADDR_W-1:0];

    assign timer_load[0] = host_write && (bus.address == REG_DELAY_TIMER);
    assign timer_load[1] = host_write && (bus.address == REG_SOUND_TIMER);
    assign timer_value = bus.writedata[BYTE_W-1:0];

    always_comb begin
        read_value = UNMAPPED_VALUE;
        if (sel_v) begin
            read_value = 32'(v_regs[bus.address[3:0]]);
        end else begin
            case (bus.address)
                REG_I:           read_value = 32'(i_reg);
                REG_SOUND_TIMER: read_value = 32'(sound_count);
                REG_DELAY_TIMER: read_value = 32'(delay_count);
                REG_PC:          read_value = {4'h0, instruction, pc};
                REG_STATE:       read_value = 32'(state);
                // Byte from last cycle's access may still be on the port
                REG_MEM: read_value = {12'h0, mem_addr, mem_pending ? mem_rdata : mem_byte};
                default: read_value = UNMAPPED_VALUE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                v_regs[i] <= '0;
            end
            i_reg <= '0;
            state <= PAUSED;
            mem_addr <= '0;
            mem_pending <= 1'b0;
            data_out <= '0;
        end else begin
            mem_pending <= mem_request;
            if (step_done) begin
                state <= PAUSED;
            end
            if (bus.chipselect) begin
                data_out <= read_value;
            end
            if (host_write) begin
                if (sel_v) begin
                    v_regs[bus.address[3:0]] <= bus.writedata[BYTE_W-1:0];
                end
                case (bus.address)
                    REG_I:   i_reg <= bus.writedata[15:0];
                    REG_MEM: mem_addr <= bus.writedata[19:8];
                    REG_STATE: begin
                        case (bus.writedata[1:0])
                            2'd0:    state <= RUNNING;
                            2'd1:    state <= STEP;
                            default: state <= PAUSED;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Keep the host byte once the port returns it
    always_ff @(posedge clk) begin
        if (mem_pending) begin
            mem_byte <= mem_rdata;
        end
    end

    // One timer loaded at a time, and the loaded value shows up next cycle
    timer_load_onehot: assert property (@(posedge clk) disable iff (reset)
        (timer_load != 2'b00) |-> $onehot(timer_load) ##1
            (($past(timer_load[0]) ? delay_count : sound_count) == $past(timer_value)));

endmodule

`default_nettype wire

//--- source/chip8_core.sv
// Chip-8 control shell seen through a 32-bit host register window
// No opcode execution, display or keypad, only fetch, timers and registers

`timescale 1ns/1ps
`default_nettype none

module chip8_core
    import chip8_pkg::*;
    import host_map_pkg::*;
#(
    parameter int TICK_DIVISOR = 833333,
    parameter int CYCLE_LENGTH = 50000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [17:0] address,
    input  logic [31:0] writedata,
    output logic [31:0] data_out,
    output logic        sound_on
);

    host_bus_t          bus;
    mem_req_t           host_req;
    logic               host_request;
    mem_req_t           fetch_req;
    logic               fetch_request;
    logic               fetch_grant;
    mem_req_t           mem_req;
    logic [BYTE_W-1:0]  mem_rdata;
    mem_addr_t          pc;
    logic [INSTR_W-1:0] instruction;
    logic               pc_load;
    mem_addr_t          pc_value;
    run_state_t         state;
    logic               step_done;
    logic [1:0]         timer_load;
    logic [BYTE_W-1:0]  timer_value;
    logic [BYTE_W-1:0]  delay_count;
    logic [BYTE_W-1:0]  sound_count;

    assign bus = '{chipselect: chipselect, write: write, address: address,
                   writedata: writedata};

    host_interface host_if (
        .clk(clk), .reset(reset), .bus(bus), .data_out(data_out),
        .mem_req(host_req), .mem_request(host_request), .mem_rdata(mem_rdata),
        .pc(pc), .instruction(instruction), .pc_load(pc_load), .pc_value(pc_value),
        .state(state), .step_done(step_done), .timer_load(timer_load),
        .timer_value(timer_value), .delay_count(delay_count), .sound_count(sound_count)
    );

    fetch_sequencer #(.CYCLE_LENGTH(CYCLE_LENGTH)) fetcher (
        .clk(clk), .reset(reset), .state(state), .pc_load(pc_load), .pc_value(pc_value),
        .fetch_request(fetch_request), .fetch_req(fetch_req), .fetch_grant(fetch_grant),
        .mem_rdata(mem_rdata), .pc(pc), .instruction(instruction), .step_done(step_done)
    );

    countdown_timers #(.TICK_DIVISOR(TICK_DIVISOR)) timers (
        .clk(clk), .reset(reset), .timer_load(timer_load), .timer_value(timer_value),
        .state(state), .delay_count(delay_count), .sound_count(sound_count),
        .sound_on(sound_on)
    );

    memory_arbiter arbiter (
        .clk(clk), .reset(reset), .host_request(host_request), .host_req(host_req),
        .fetch_request(fetch_request), .fetch_req(fetch_req), .fetch_grant(fetch_grant),
        .mem_req(mem_req)
    );

    program_memory memory (
        .clk(clk), .mem_req(mem_req), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- verification/chip8_core_tb.sv
// Drives chip8_core through its host register window with fast timer and cycle settings
// Memory outside the loaded bytes is never checked, its contents are undefined

`timescale 1ns/1ps
`default_nettype none

module chip8_core_tb
    import host_map_pkg::*;
();

    localparam int TICK_DIVISOR   = 8;
    localparam int CYCLE_LENGTH   = 20;
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [17:0] address;
    logic [31:0] writedata;
    logic [31:0] data_out;
    logic        sound_on;

    // Pending comparison, held for one cycle by check_value
    logic        check_en;
    logic [31:0] check_exp;
    logic [31:0] check_act;
    string       check_name;

    integer      seed = 32'h38ea;
    int          error_count = 0;
    int          check_count = 0;
    int          test_errors_start = 0;
    int          cycle_count = 0;
    logic [31:0] rnd;
    logic [31:0] value;
    logic [7:0]  v_model [16];
    logic [7:0]  mem_model [4096];
    logic [11:0] mem_addrs [8];
    logic [15:0] i_model;
    logic [7:0]  timer_n;
    logic [11:0] pc_val;
    logic [11:0] rd_addr;

    chip8_core #(
        .TICK_DIVISOR(TICK_DIVISOR),
        .CYCLE_LENGTH(CYCLE_LENGTH)
    ) UUT (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata), .data_out(data_out),
        .sound_on(sound_on)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    value_matches: assert property (@(posedge clk) check_en |-> (check_act == check_exp))
        else begin
            error_count = error_count + 1;
            $display("CHECK FAILED %s: expected %h, actual %h", check_name, check_exp,
                     check_act);
        end

    reset_clears_outputs: assert property (@(posedge clk)
        reset |=> (data_out == 32'h0 && !sound_on))
        else begin
            error_count = error_count + 1;
            $display("Reset did not clear data_out and sound_on");
        end

    task automatic host_write(input logic [17:0] addr, input logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write <= 1'b1;
        address <= addr;
        writedata <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic host_read(input logic [17:0] addr, output logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write <= 1'b0;
        address <= addr;
        @(posedge clk);
        chipselect <= 1'b0;
        @(negedge clk);
        data = data_out;
    endtask

    task automatic mem_write(input logic [11:0] addr, input logic [7:0] data);
        host_write(REG_MEM, {11'h0, 1'b1, addr, data});
    endtask

    // Set the address, then two back to back reads, the second returns the byte
    task automatic mem_read(input logic [11:0] addr, output logic [31:0] data);
        host_write(REG_MEM, {11'h0, 1'b0, addr, 8'h00});
        @(posedge clk);
        chipselect <= 1'b1;
        write <= 1'b0;
        address <= REG_MEM;
        writedata <= 32'h0;
        @(posedge clk);
        @(posedge clk);
        chipselect <= 1'b0;
        @(negedge clk);
        data = data_out;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        @(posedge clk);
        check_name <= name;
        check_exp <= exp;
        check_act <= act;
        check_en <= 1'b1;
        check_count = check_count + 1;
        @(posedge clk);
        check_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        $display("%s finished with %0d errors", name, error_count - test_errors_start);
        test_errors_start = error_count;
    endtask

    task automatic reset_state_test();
        host_read(REG_STATE, value);
        check_value("reset state", 32'd2, value);
        host_read(REG_PC, value);
        check_value("reset pc", 32'h200, {20'h0, value[11:0]});
        check_value("reset sound_on", 32'd0, 32'(sound_on));
        finish_test("reset state");
    endtask

    task automatic register_test();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            v_model[i] = rnd[7:0];
            host_write(REG_V_BASE + 18'(i), {24'h0, rnd[7:0]});
        end
        rnd = $random(seed);
        i_model = rnd[15:0];
        host_write(REG_I, {16'h0, i_model});
        for (int i = 0; i < 16; i++) begin
            host_read(REG_V_BASE + 18'(i), value);
            check_value("v register", {24'h0, v_model[i]}, value);
        end
        host_read(REG_I, value);
        check_value("i register", {16'h0, i_model}, value);
        host_read(18'h13, value);
        check_value("unmapped offset", 32'd101, value);
        finish_test("registers");
    endtask

    task automatic memory_test();
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            mem_addrs[k] = rnd[19:8];
            mem_model[rnd[19:8]] = rnd[7:0];
            mem_write(rnd[19:8], rnd[7:0]);
        end
        for (int k = 0; k < 8; k++) begin
            mem_read(mem_addrs[k], value);
            check_value("memory readback", {12'h0, mem_addrs[k], mem_model[mem_addrs[k]]},
                        value);
        end
        finish_test("memory");
    endtask

    task automatic timer_test();
        rnd = $random(seed);
        timer_n = 8'd5 + 8'(rnd[2:0]);
        host_write(REG_DELAY_TIMER, 32'(timer_n));
        host_read(REG_DELAY_TIMER, value);
        // One tick may fall between load and read
        check_value("delay load",
                    (value == 32'(timer_n - 8'd1)) ? 32'(timer_n - 8'd1) : 32'(timer_n),
                    value);
        repeat ((timer_n + 1) * TICK_DIVISOR) @(posedge clk);
        host_read(REG_DELAY_TIMER, value);
        check_value("delay expired", 32'd0, value);
        host_write(REG_STATE, 32'd0);
        host_write(REG_SOUND_TIMER, 32'(timer_n));
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("sound on while running", 32'd1, 32'(sound_on));
        host_write(REG_STATE, 32'd2);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("sound off while paused", 32'd0, 32'(sound_on));
        host_write(REG_STATE, 32'd0);
        repeat ((timer_n + 1) * TICK_DIVISOR) @(posedge clk);
        host_read(REG_SOUND_TIMER, value);
        check_value("sound expired", 32'd0, value);
        check_value("sound off at zero", 32'd0, 32'(sound_on));
        host_write(REG_STATE, 32'd2);
        // Let the instruction in flight complete
        repeat (CYCLE_LENGTH + 5) @(posedge clk);
        finish_test("timers");
    endtask

    task automatic step_test();
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            mem_model[12'h200 + 12'(k)] = rnd[7:0];
            mem_write(12'h200 + 12'(k), rnd[7:0]);
        end
        host_write(REG_PC, 32'h200);
        host_write(REG_STATE, 32'd1);
        repeat (40) @(posedge clk);
        host_read(REG_STATE, value);
        check_value("step ends paused", 32'd2, value);
        host_read(REG_PC, value);
        check_value("step pc", 32'h202, {20'h0, value[11:0]});
        check_value("step instruction", {16'h0, mem_model[12'h200], mem_model[12'h201]},
                    {16'h0, value[27:12]});
        finish_test("step");
    endtask

    task automatic running_test();
        for (int k = 0; k < 32; k++) begin
            rnd = $random(seed);
            mem_model[12'h200 + 12'(k)] = rnd[7:0];
            mem_write(12'h200 + 12'(k), rnd[7:0]);
        end
        host_write(REG_PC, 32'h200);
        host_write(REG_STATE, 32'd0);
        // Host reads compete with the fetcher for the port
        for (int k = 0; k < 12; k++) begin
            rnd = $random(seed);
            rd_addr = 12'h200 + 12'(rnd[4:0]);
            mem_read(rd_addr, value);
            check_value("memory read while running", {12'h0, rd_addr, mem_model[rd_addr]},
                        value);
        end
        host_write(REG_STATE, 32'd2);
        repeat (CYCLE_LENGTH + 5) @(posedge clk);
        host_read(REG_PC, value);
        pc_val = value[11:0];
        check_value("pc even and advanced", 32'd1,
                    32'(pc_val[0] == 1'b0 && pc_val > 12'h200));
        check_value("running instruction",
                    {16'h0, mem_model[pc_val - 12'd2], mem_model[pc_val - 12'd1]},
                    {16'h0, value[27:12]});
        finish_test("running with host traffic");
    endtask

    initial begin
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = 18'h0;
        writedata = 32'h0;
        check_en = 1'b0;
        check_exp = 32'h0;
        check_act = 32'h0;
        check_name = "";
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reset_state_test();
        register_test();
        memory_test();
        timer_test();
        step_test();
        running_test();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/chip8_pkg.sv
source/host_map_pkg.sv
source/program_memory.sv
source/memory_arbiter.sv
source/fetch_sequencer.sv
source/countdown_timers.sv
source/host_interface.sv
source/chip8_core.sv
verification/chip8_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the chip8_core testbench with Verilator, run from the project root

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module chip8_core_tb \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vchip8_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
